// ==== rtl/dmi_jtag_pkg.sv ====
package dmi_jtag_pkg;

   // dmi frame holds address over data over op
   localparam int DMI_ABITS = 7;
   localparam int DMI_DATA_W = 32;
   localparam int DMI_FRAME_W = DMI_ABITS + DMI_DATA_W + 2;
   localparam int DTMCS_W = 32;
   localparam int DMISTAT_LSB = 10;
   localparam int IR_LEN = 5;
   localparam int DR_LEN_W = 6;

   // tck generation
   localparam int TCK_HALF_CLOCKS = 4;
   localparam int TCK_DIV_W = $clog2(TCK_HALF_CLOCKS);
   localparam int TAP_RESET_TCKS = 10;

   // flow control
   localparam int REQ_DEPTH = 4;
   localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
   localparam int RESP_CREDIT_W = 4;

   typedef enum logic [1:0] {
      dmi_nop   = 2'd0,
      dmi_read  = 2'd1,
      dmi_write = 2'd2
   } dmi_op_e;

   typedef enum logic [1:0] {
      dmi_ok     = 2'd0,
      dmi_failed = 2'd2,
      dmi_busy   = 2'd3
   } dmi_status_e;

   typedef enum logic [IR_LEN-1:0] {
      ir_dtmcs = 5'h10,
      ir_dmi   = 5'h11
   } jtag_ir_e;

   // ieee 1149.1 controller states
   typedef enum logic [3:0] {
      ts_test_logic_reset = 4'd0,
      ts_run_test_idle    = 4'd1,
      ts_select_dr        = 4'd2,
      ts_capture_dr       = 4'd3,
      ts_shift_dr         = 4'd4,
      ts_exit1_dr         = 4'd5,
      ts_pause_dr         = 4'd6,
      ts_exit2_dr         = 4'd7,
      ts_update_dr        = 4'd8,
      ts_select_ir        = 4'd9,
      ts_capture_ir       = 4'd10,
      ts_shift_ir         = 4'd11,
      ts_exit1_ir         = 4'd12,
      ts_pause_ir         = 4'd13,
      ts_exit2_ir         = 4'd14,
      ts_update_ir        = 4'd15
   } tap_state_e;

   typedef struct packed {
      logic [DMI_ABITS-1:0]  addr;
      logic [DMI_DATA_W-1:0] data;
      dmi_op_e               op;
   } dmi_req_t;

   typedef struct packed {
      logic [DMI_DATA_W-1:0] data;
      dmi_status_e           status;
   } dmi_resp_t;

   typedef struct packed {
      jtag_ir_e               ir;
      logic [DR_LEN_W-1:0]    dr_len;
      logic [DMI_FRAME_W-1:0] dr_data;
   } scan_req_t;

endpackage

// ==== rtl/dmi_req_buffer.sv ====
`timescale 1ns/100ps

module dmi_req_buffer (
   input  logic                   clock,
   input  logic                   rst_n,
   input  logic                   req_valid,
   input  dmi_jtag_pkg::dmi_req_t req,
   input  logic                   pop,
   output logic                   not_empty,
   output dmi_jtag_pkg::dmi_req_t head,
   output logic                   req_credit
);
   import dmi_jtag_pkg::*;

   dmi_req_t             mem [REQ_DEPTH];
   logic [REQ_PTR_W-1:0] wr_ptr;
   logic [REQ_PTR_W-1:0] rd_ptr;
   logic [REQ_PTR_W:0]   count;
   logic                 do_pop;

   assign not_empty = (count != '0);
   assign do_pop = pop && not_empty;
   assign head = mem[rd_ptr];

   // fifo entries
   always_ff @(posedge clock) begin
      if (req_valid) begin
         mem[wr_ptr] <= req;
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         req_credit <= 1'b0;
      end else begin
         if (req_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({req_valid, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: ;
         endcase
         // one credit back per entry leaving
         req_credit <= do_pop;
      end
   end

endmodule

// ==== rtl/jtag_tap_driver.sv ====
`timescale 1ns/100ps

module jtag_tap_driver (
   input  logic                                 clock,
   input  logic                                 rst_n,
   input  logic                                 scan_start,
   input  logic                                 tap_reset,
   input  dmi_jtag_pkg::scan_req_t              scan,
   input  logic                                 tdo,
   output logic                                 tck,
   output logic                                 tms,
   output logic                                 tdi,
   output logic                                 trst_n,
   output logic                                 scan_done,
   output logic [dmi_jtag_pkg::DMI_FRAME_W-1:0] tdo_capture
);
   import dmi_jtag_pkg::*;

   tap_state_e             tap_state;
   logic                   active;
   logic                   ir_phase;
   logic                   last_fall;
   logic [TCK_DIV_W-1:0]   div_cnt;
   logic [DR_LEN_W-1:0]    bit_cnt;
   logic [DR_LEN_W-1:0]    dr_len_q;
   logic [IR_LEN-1:0]      ir_sr;
   logic [DMI_FRAME_W-1:0] dr_sr;
   logic                   half_tick;
   logic                   rise;
   logic                   fall;
   logic                   start;
   logic                   tms_next;
   logic                   tdi_next;

   function automatic tap_state_e tap_next(tap_state_e cur, logic tms_in);
      case (cur)
         ts_test_logic_reset: return tms_in ? ts_test_logic_reset : ts_run_test_idle;
         ts_run_test_idle:    return tms_in ? ts_select_dr : ts_run_test_idle;
         ts_select_dr:        return tms_in ? ts_select_ir : ts_capture_dr;
         ts_capture_dr:       return tms_in ? ts_exit1_dr : ts_shift_dr;
         ts_shift_dr:         return tms_in ? ts_exit1_dr : ts_shift_dr;
         ts_exit1_dr:         return tms_in ? ts_update_dr : ts_pause_dr;
         ts_pause_dr:         return tms_in ? ts_exit2_dr : ts_pause_dr;
         ts_exit2_dr:         return tms_in ? ts_update_dr : ts_shift_dr;
         ts_update_dr:        return tms_in ? ts_select_dr : ts_run_test_idle;
         ts_select_ir:        return tms_in ? ts_test_logic_reset : ts_capture_ir;
         ts_capture_ir:       return tms_in ? ts_exit1_ir : ts_shift_ir;
         ts_shift_ir:         return tms_in ? ts_exit1_ir : ts_shift_ir;
         ts_exit1_ir:         return tms_in ? ts_update_ir : ts_pause_ir;
         ts_pause_ir:         return tms_in ? ts_exit2_ir : ts_pause_ir;
         ts_exit2_ir:         return tms_in ? ts_update_ir : ts_shift_ir;
         default:             return tms_in ? ts_select_dr : ts_run_test_idle;
      endcase
   endfunction

   assign trst_n = 1'b1;
   assign start = scan_start && !active;
   assign half_tick = active && (div_cnt == TCK_DIV_W'(TCK_HALF_CLOCKS - 1));
   assign rise = half_tick && !tck;
   assign fall = half_tick && tck;

   // pins for the coming rising edge as picked from the state just entered
   always_comb begin
      tms_next = 1'b1;
      tdi_next = 1'b0;
      case (tap_state)
         ts_test_logic_reset: tms_next = (bit_cnt < DR_LEN_W'(TAP_RESET_TCKS));
         ts_select_dr:        tms_next = ir_phase;
         ts_select_ir, ts_capture_ir, ts_capture_dr, ts_update_dr: tms_next = 1'b0;
         ts_shift_ir: begin
            tdi_next = ir_sr[0];
            tms_next = (bit_cnt == DR_LEN_W'(IR_LEN - 1));
         end
         ts_shift_dr: begin
            tdi_next = dr_sr[0];
            tms_next = (bit_cnt == dr_len_q - DR_LEN_W'(1));
         end
         default: ;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         tck <= 1'b0;
         tms <= 1'b1;
         tdi <= 1'b0;
         tap_state <= ts_test_logic_reset;
         active <= 1'b0;
         ir_phase <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
         last_fall <= 1'b0;
         scan_done <= 1'b0;
      end else begin
         if (start) begin
            active <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
            ir_phase <= 1'b1;
            if (tap_reset) begin
               tap_state <= ts_test_logic_reset;
            end
         end else if (active) begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
         end
         if (rise) begin
            tck <= 1'b1;
            tap_state <= tap_next(tap_state, tms);
            // counts shifted bits, or reset edges while in test-logic-reset
            if (tap_state inside {ts_test_logic_reset, ts_shift_ir, ts_shift_dr}) begin
               bit_cnt <= bit_cnt + 1'b1;
            end else begin
               bit_cnt <= '0;
            end
            if (tap_state == ts_exit1_ir) begin
               ir_phase <= 1'b0;
            end
         end
         if (fall) begin
            tck <= 1'b0;
            tms <= tms_next;
            tdi <= tdi_next;
            // walk ends once back in run-test/idle
            if (tap_state == ts_run_test_idle) begin
               active <= 1'b0;
            end
         end
         last_fall <= fall && (tap_state == ts_run_test_idle);
         scan_done <= last_fall;
      end
   end

   always_ff @(posedge clock) begin
      if (start) begin
         ir_sr <= scan.ir;
         dr_sr <= scan.dr_data;
         dr_len_q <= scan.dr_len;
         tdo_capture <= '0;
      end else if (rise) begin
         if (tap_state == ts_shift_ir) begin
            ir_sr <= ir_sr >> 1;
         end
         if (tap_state == ts_shift_dr) begin
            dr_sr <= dr_sr >> 1;
            tdo_capture[bit_cnt] <= tdo;
         end
      end
   end

endmodule

// ==== rtl/dmi_access_seq.sv ====
`timescale 1ns/100ps

module dmi_access_seq (
   input  logic                                 clock,
   input  logic                                 rst_n,
   input  logic                                 not_empty,
   input  dmi_jtag_pkg::dmi_req_t               head,
   input  logic                                 scan_done,
   input  logic [dmi_jtag_pkg::DMI_FRAME_W-1:0] tdo_capture,
   input  logic                                 resp_accepted,
   output logic                                 pop,
   output logic                                 scan_start,
   output logic                                 tap_reset,
   output dmi_jtag_pkg::scan_req_t              scan,
   output logic                                 resp_push,
   output dmi_jtag_pkg::dmi_resp_t              resp
);
   import dmi_jtag_pkg::*;

   typedef enum logic [2:0] {
      tap_init,
      idle,
      poll_req,
      write,
      poll_resp,
      read,
      done
   } seq_state_e;

   seq_state_e state;
   dmi_req_t   cur_req;
   logic       in_scan;
   logic       dmi_free;

   assign dmi_free = (tdo_capture[DMISTAT_LSB +: 2] == 2'b00);
   assign pop = (state == idle) && not_empty;
   assign tap_reset = (state == tap_init);
   assign resp_push = (state == done);

   // dtmcs poll by default
   always_comb begin
      scan.ir = ir_dtmcs;
      scan.dr_len = DR_LEN_W'(DTMCS_W);
      scan.dr_data = '0;
      case (state)
         write: begin
            scan.ir = ir_dmi;
            scan.dr_len = DR_LEN_W'(DMI_FRAME_W);
            scan.dr_data = cur_req;
         end
         read: begin
            scan.ir = ir_dmi;
            scan.dr_len = DR_LEN_W'(DMI_FRAME_W);
            scan.dr_data = dmi_req_t'{addr: '0, data: '0, op: dmi_nop};
         end
         default: ;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state <= tap_init;
         in_scan <= 1'b0;
         scan_start <= 1'b0;
      end else begin
         scan_start <= 1'b0;
         case (state)
            idle: begin
               if (not_empty) begin
                  state <= poll_req;
               end
            end
            // hold the response until a credit is there
            done: begin
               if (resp_accepted) begin
                  state <= idle;
               end
            end
            default: begin
               if (!in_scan) begin
                  scan_start <= 1'b1;
                  in_scan <= 1'b1;
               end else if (scan_done) begin
                  in_scan <= 1'b0;
                  case (state)
                     tap_init: state <= idle;
                     poll_req: state <= dmi_free ? write : poll_req;
                     write: state <= poll_resp;
                     poll_resp: state <= dmi_free ? read : poll_resp;
                     read: state <= done;
                     default: state <= idle;
                  endcase
               end
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (pop) begin
         cur_req <= head;
      end
      // status in bits 1:0, data above it
      if ((state == read) && scan_done) begin
         resp.status <= dmi_status_e'(tdo_capture[1:0]);
         resp.data <= tdo_capture[DMI_DATA_W+1:2];
      end
   end

endmodule

// ==== rtl/dmi_resp_sender.sv ====
`timescale 1ns/100ps

module dmi_resp_sender (
   input  logic                    clock,
   input  logic                    rst_n,
   input  logic                    resp_credit,
   input  logic                    resp_push,
   input  dmi_jtag_pkg::dmi_resp_t resp,
   output logic                    resp_accepted,
   output logic                    resp_valid,
   output dmi_jtag_pkg::dmi_resp_t resp_out
);
   import dmi_jtag_pkg::*;

   logic [RESP_CREDIT_W-1:0] credit_cnt;
   logic                     credit_add;

   assign resp_accepted = resp_push && (credit_cnt != '0);
   // grants beyond the counter range are dropped
   assign credit_add = resp_credit && ((credit_cnt != '1) || resp_accepted);

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= '0;
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= resp_accepted;
         case ({credit_add, resp_accepted})
            2'b10: credit_cnt <= credit_cnt + 1'b1;
            2'b01: credit_cnt <= credit_cnt - 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (resp_accepted) begin
         resp_out <= resp;
      end
   end

endmodule

// ==== rtl/dmi_jtag_master.sv ====
`timescale 1ns/100ps

module dmi_jtag_master (
   input  logic                    clock,
   input  logic                    rst_n,
   input  logic                    req_valid,
   input  dmi_jtag_pkg::dmi_req_t  req,
   input  logic                    resp_credit,
   input  logic                    tdo,
   output logic                    req_credit,
   output logic                    resp_valid,
   output dmi_jtag_pkg::dmi_resp_t resp,
   output logic                    tck,
   output logic                    tms,
   output logic                    tdi,
   output logic                    trst_n
);
   import dmi_jtag_pkg::*;

   logic                   not_empty;
   dmi_req_t               head;
   logic                   pop;
   logic                   scan_start;
   logic                   tap_reset;
   scan_req_t              scan;
   logic                   scan_done;
   logic [DMI_FRAME_W-1:0] tdo_capture;
   logic                   resp_push;
   logic                   resp_accepted;
   dmi_resp_t              seq_resp;

   dmi_req_buffer u_req_buffer (
      .clock      (clock),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .pop        (pop),
      .not_empty  (not_empty),
      .head       (head),
      .req_credit (req_credit)
   );

   dmi_access_seq u_access_seq (
      .clock         (clock),
      .rst_n         (rst_n),
      .not_empty     (not_empty),
      .head          (head),
      .scan_done     (scan_done),
      .tdo_capture   (tdo_capture),
      .resp_accepted (resp_accepted),
      .pop           (pop),
      .scan_start    (scan_start),
      .tap_reset     (tap_reset),
      .scan          (scan),
      .resp_push     (resp_push),
      .resp          (seq_resp)
   );

   jtag_tap_driver u_tap_driver (
      .clock       (clock),
      .rst_n       (rst_n),
      .scan_start  (scan_start),
      .tap_reset   (tap_reset),
      .scan        (scan),
      .tdo         (tdo),
      .tck         (tck),
      .tms         (tms),
      .tdi         (tdi),
      .trst_n      (trst_n),
      .scan_done   (scan_done),
      .tdo_capture (tdo_capture)
   );

   dmi_resp_sender u_resp_sender (
      .clock         (clock),
      .rst_n         (rst_n),
      .resp_credit   (resp_credit),
      .resp_push     (resp_push),
      .resp          (seq_resp),
      .resp_accepted (resp_accepted),
      .resp_valid    (resp_valid),
      .resp_out      (resp)
   );

endmodule

// ==== tb/jtag_dtm_model.sv ====
`timescale 1ns/100ps

module jtag_dtm_model (
   input  logic rst_n,
   input  logic tck,
   input  logic tms,
   input  logic tdi,
   input  logic trst_n,
   input  int   busy_polls,
   output logic tdo
);
   import dmi_jtag_pkg::*;

   tap_state_e             st;
   logic [IR_LEN-1:0]      ir;
   logic [IR_LEN-1:0]      ir_sr;
   logic [DMI_FRAME_W-1:0] dr_sr;
   logic [DMI_DATA_W-1:0]  regs [128];
   logic [DMI_DATA_W-1:0]  res_data;
   dmi_status_e            res_status;
   int                     busy_left;
   logic [DMI_ABITS-1:0]   upd_addr;
   logic [DMI_DATA_W-1:0]  upd_data;
   logic [1:0]             upd_op;
   logic [DTMCS_W-1:0]     dtmcs;

   assign upd_addr = dr_sr[DMI_FRAME_W-1 -: DMI_ABITS];
   assign upd_data = dr_sr[DMI_DATA_W+1:2];
   assign upd_op = dr_sr[1:0];
   // dmistat over abits of 7 over version 1
   assign dtmcs = {20'd0, (busy_left > 0) ? 2'b11 : 2'b00, 6'd7, 4'd1};

   function automatic tap_state_e next_state(tap_state_e s, logic m);
      case (s)
         ts_test_logic_reset: return m ? ts_test_logic_reset : ts_run_test_idle;
         ts_run_test_idle, ts_update_dr, ts_update_ir:
            return m ? ts_select_dr : ts_run_test_idle;
         ts_select_dr:  return m ? ts_select_ir : ts_capture_dr;
         ts_capture_dr, ts_shift_dr: return m ? ts_exit1_dr : ts_shift_dr;
         ts_exit1_dr:   return m ? ts_update_dr : ts_pause_dr;
         ts_pause_dr:   return m ? ts_exit2_dr : ts_pause_dr;
         ts_exit2_dr:   return m ? ts_update_dr : ts_shift_dr;
         ts_select_ir:  return m ? ts_test_logic_reset : ts_capture_ir;
         ts_capture_ir, ts_shift_ir: return m ? ts_exit1_ir : ts_shift_ir;
         ts_exit1_ir:   return m ? ts_update_ir : ts_pause_ir;
         ts_pause_ir:   return m ? ts_exit2_ir : ts_pause_ir;
         default:       return m ? ts_update_ir : ts_shift_ir;
      endcase
   endfunction

   always @(posedge tck or negedge rst_n) begin
      if (!rst_n || !trst_n) begin
         st <= ts_test_logic_reset;
         ir <= ir_dtmcs;
         ir_sr <= '0;
         dr_sr <= '0;
         busy_left <= 0;
         res_data <= '0;
         res_status <= dmi_ok;
         for (int i = 0; i < 128; i++) begin
            regs[i] <= '0;
         end
      end else begin
         case (st)
            ts_test_logic_reset: ir <= ir_dtmcs;
            ts_capture_ir: ir_sr <= 5'b00001;
            ts_shift_ir: ir_sr <= {tdi, ir_sr[IR_LEN-1:1]};
            ts_update_ir: ir <= ir_sr;
            ts_capture_dr: begin
               if (ir == ir_dmi) begin
                  dr_sr <= {7'd0, res_data, res_status};
               end else begin
                  dr_sr <= {9'd0, dtmcs};
                  if (busy_left > 0) begin
                     busy_left <= busy_left - 1;
                  end
               end
            end
            ts_shift_dr: begin
               if (ir == ir_dmi) begin
                  dr_sr <= {tdi, dr_sr[DMI_FRAME_W-1:1]};
               end else begin
                  dr_sr <= {9'd0, tdi, dr_sr[DTMCS_W-1:1]};
               end
            end
            // the dmi op runs here
            ts_update_dr: begin
               if (ir == ir_dmi) begin
                  busy_left <= busy_polls;
                  res_status <= dmi_ok;
                  res_data <= '0;
                  if (upd_addr >= 7'h60) begin
                     res_status <= dmi_failed;
                  end else if (upd_op == 2'd1) begin
                     res_data <= regs[upd_addr];
                  end else if (upd_op == 2'd2) begin
                     regs[upd_addr] <= upd_data;
                     res_data <= upd_data;
                  end
               end
            end
            default: ;
         endcase
         st <= next_state(st, tms);
      end
   end

   always @(negedge tck or negedge rst_n) begin
      if (!rst_n) begin
         tdo <= 1'b0;
      end else begin
         tdo <= (st == ts_shift_ir) ? ir_sr[0] : dr_sr[0];
      end
   end

endmodule

// ==== tb/dmi_jtag_chk.sv ====
`timescale 1ns/100ps

module dmi_jtag_chk (
   input logic clock,
   input logic rst_n,
   input logic tck,
   input logic tms,
   input logic tdi,
   input logic scan_done,
   input logic req_valid,
   input logic pop,
   input logic not_empty
);
   import dmi_jtag_pkg::*;

   int occupancy;

   // shadow count of the request fifo
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         occupancy <= 0;
      end else begin
         occupancy <= occupancy + (req_valid ? 1 : 0) - ((pop && not_empty) ? 1 : 0);
      end
   end

   a_pins_stable: assert property (@(posedge clock) disable iff (!rst_n)
      tck |-> ($stable(tms) && $stable(tdi)))
      else $error("tms or tdi moved while tck high");

   a_done_pulse: assert property (@(posedge clock) disable iff (!rst_n)
      scan_done |=> !scan_done)
      else $error("scan_done longer than one cycle");

   a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
      req_valid |-> (occupancy < REQ_DEPTH))
      else $error("request pushed into a full fifo");

endmodule

bind dmi_jtag_master dmi_jtag_chk u_chk (
   .clock     (clock),
   .rst_n     (rst_n),
   .tck       (tck),
   .tms       (tms),
   .tdi       (tdi),
   .scan_done (scan_done),
   .req_valid (req_valid),
   .pop       (pop),
   .not_empty (not_empty)
);

// ==== tb/tb_dmi_jtag_master.sv ====
`timescale 1ns/100ps

module tb_dmi_jtag_master;
   import dmi_jtag_pkg::*;

   typedef struct {
      string     name;
      dmi_req_t  req;
      int        busy;
      dmi_resp_t exp;
      int        burst;
   } vec_t;

   logic      clock;
   logic      rst_n;
   logic      req_valid;
   dmi_req_t  req;
   logic      resp_credit;
   logic      tdo;
   logic      req_credit;
   logic      resp_valid;
   dmi_resp_t resp;
   logic      tck;
   logic      tms;
   logic      tdi;
   logic      trst_n;
   int        busy_polls;

   vec_t      vecs [$];
   dmi_resp_t resp_q [$];
   int        seed;
   int        errors;
   int        pass_cnt;
   int        fail_cnt;
   int        req_credits;
   int        credits_back;
   int        sent;
   int        max_busy;
   int        hold_clocks;
   longint    tck_period_ns;
   longint    wd_ns;

   dmi_jtag_master u_dut (
      .clock       (clock),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req         (req),
      .resp_credit (resp_credit),
      .tdo         (tdo),
      .req_credit  (req_credit),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .tck         (tck),
      .tms         (tms),
      .tdi         (tdi),
      .trst_n      (trst_n)
   );

   jtag_dtm_model u_target (
      .rst_n      (rst_n),
      .tck        (tck),
      .tms        (tms),
      .tdi        (tdi),
      .trst_n     (trst_n),
      .busy_polls (busy_polls),
      .tdo        (tdo)
   );

   always #5 clock = ~clock;

   // outputs settle long before the falling edge
   always @(negedge clock) begin
      if (rst_n && req_credit) begin
         req_credits++;
         credits_back++;
      end
      if (rst_n && resp_valid) begin
         resp_q.push_back(resp);
      end
   end

   task automatic check_resp(input string name, input dmi_resp_t exp, input dmi_resp_t act);
      if (exp !== act) begin
         errors++;
         $display("mismatch %s: expected %s/%h, actual %s/%h", name,
                  exp.status.name(), exp.data, act.status.name(), act.data);
      end
   endtask

   task automatic check_req_credit(input string name, input int exp, input int act);
      if (exp != act) begin
         errors++;
         $display("mismatch %s: expected %0d credits, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_pin(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         errors++;
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic finish_test(input string name, input int err0);
      if (errors == err0) begin
         pass_cnt++;
         $display("ok   %s", name);
      end else begin
         fail_cnt++;
         $display("FAIL %s", name);
      end
   endtask

   // all tasks below start and end 1 ns after a rising edge
   task automatic send_req(input dmi_req_t r);
      while (req_credits == 0) begin
         @(posedge clock);
         #1;
      end
      req = r;
      req_valid = 1'b1;
      req_credits--;
      sent++;
      @(posedge clock);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic grant_credit();
      int gap;
      gap = $random(seed) & 32'h7;
      repeat (gap) begin
         @(posedge clock);
         #1;
      end
      resp_credit = 1'b1;
      @(posedge clock);
      #1;
      resp_credit = 1'b0;
   endtask

   task automatic wait_resp_count(input int n);
      while (resp_q.size() < n) begin
         @(posedge clock);
      end
      #1;
   endtask

   task automatic run_single(input int i);
      int        err0;
      dmi_resp_t got;
      err0 = errors;
      busy_polls = vecs[i].busy;
      send_req(vecs[i].req);
      grant_credit();
      wait_resp_count(1);
      got = resp_q.pop_front();
      check_resp(vecs[i].name, vecs[i].exp, got);
      finish_test(vecs[i].name, err0);
   endtask

   task automatic run_burst(input int first, input int n);
      int        err0;
      dmi_resp_t got;
      err0 = errors;
      busy_polls = 0;
      for (int k = 0; k < n; k++) begin
         send_req(vecs[first+k].req);
      end
      repeat (hold_clocks) @(posedge clock);
      #1;
      if (resp_q.size() != 0) begin
         errors++;
         $display("a response came out before any credit was granted");
      end
      finish_test("credit_hold", err0);
      for (int k = 0; k < n; k++) begin
         grant_credit();
      end
      wait_resp_count(n);
      for (int k = 0; k < n; k++) begin
         err0 = errors;
         got = resp_q.pop_front();
         check_resp(vecs[first+k].name, vecs[first+k].exp, got);
         finish_test(vecs[first+k].name, err0);
      end
   endtask

   task automatic read_vectors();
      int          fd;
      int          n;
      string       line;
      string       nm;
      logic [31:0] v_op;
      logic [31:0] v_addr;
      logic [31:0] v_data;
      logic [31:0] v_st;
      logic [31:0] v_exp;
      int          v_busy;
      int          v_mode;
      vec_t        v;
      fd = $fopen("tb/dmi_vectors.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open tb/dmi_vectors.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != 8'h23) begin
               n = $sscanf(line, "%s %h %h %h %d %h %h %d", nm, v_op, v_addr, v_data,
                           v_busy, v_st, v_exp, v_mode);
               if (n == 8) begin
                  v.name = nm;
                  v.req.addr = v_addr[DMI_ABITS-1:0];
                  v.req.data = v_data;
                  v.req.op = dmi_op_e'(v_op[1:0]);
                  v.busy = v_busy;
                  v.exp.status = dmi_status_e'(v_st[1:0]);
                  v.exp.data = v_exp;
                  v.burst = v_mode;
                  vecs.push_back(v);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      int i;
      int j;
      int err0;
      clock = 1'b0;
      rst_n = 1'b0;
      req_valid = 1'b0;
      req = '0;
      resp_credit = 1'b0;
      busy_polls = 0;
      seed = 32'hbcd3;
      errors = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      req_credits = REQ_DEPTH;
      credits_back = 0;
      sent = 0;
      tck_period_ns = 2 * TCK_HALF_CLOCKS * 10;
      read_vectors();
      wd_ns = 0;
      max_busy = 0;
      foreach (vecs[k]) begin
         wd_ns += longint'(vecs[k].busy + 4) * 2 * 100 * tck_period_ns;
         if (vecs[k].busy > max_busy) begin
            max_busy = vecs[k].busy;
         end
      end
      // one whole access plus busy polls left over from the access before it
      hold_clocks = (max_busy + 5) * 2 * (6 + IR_LEN + DMI_FRAME_W) * TCK_HALF_CLOCKS + 100;
      fork
         begin
            #(wd_ns);
            $display("watchdog expired after %0d ns with responses still missing", wd_ns);
            $display("Test failures found");
            $finish;
         end
      join_none
      repeat (4) @(posedge clock);
      #1;
      rst_n = 1'b1;
      err0 = errors;
      check_pin("reset tck", 1'b0, tck);
      check_pin("reset tms", 1'b1, tms);
      check_pin("reset tdi", 1'b0, tdi);
      check_pin("reset trst_n", 1'b1, trst_n);
      check_pin("reset resp_valid", 1'b0, resp_valid);
      check_pin("reset req_credit", 1'b0, req_credit);
      finish_test("reset_state", err0);
      i = 0;
      while (i < vecs.size()) begin
         if (vecs[i].burst != 0) begin
            j = i;
            while (j < vecs.size() && vecs[j].burst != 0 && (j - i) < REQ_DEPTH) begin
               j++;
            end
            run_burst(i, j - i);
            i = j;
         end else begin
            run_single(i);
            i++;
         end
      end
      repeat (4) @(posedge clock);
      #1;
      err0 = errors;
      check_req_credit("credits returned", sent, credits_back);
      check_req_credit("credits held", REQ_DEPTH, req_credits);
      finish_test("credit_return", err0);
      $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== tb/dmi_vectors.txt ====
# name op addr data busy_polls exp_status exp_data burst
# hex: op addr data exp_status exp_data, decimal: busy_polls burst (1 = back to back)
wr_a5     2 05 deadbeef 0 0 deadbeef 0
rd_a5     1 05 00000000 0 0 deadbeef 0
wr_busy   2 10 12345678 3 0 12345678 0
rd_busy   1 10 00000000 2 0 12345678 0
rd_zero   1 20 00000000 0 0 00000000 0
nop_busy  0 00 00000000 1 0 00000000 0
wr_err    2 60 cafef00d 0 2 00000000 0
rd_err    1 7f 00000000 2 2 00000000 0
b_wr_30   2 30 a5a5a5a5 0 0 a5a5a5a5 1
b_rd_30   1 30 00000000 0 0 a5a5a5a5 1
b_rd_05   1 05 00000000 0 0 deadbeef 1
b_rd_err  1 65 00000000 0 2 00000000 1

// ==== flist.f ====
rtl/dmi_jtag_pkg.sv
rtl/dmi_req_buffer.sv
rtl/jtag_tap_driver.sv
rtl/dmi_access_seq.sv
rtl/dmi_resp_sender.sv
rtl/dmi_jtag_master.sv
tb/jtag_dtm_model.sv
tb/dmi_jtag_chk.sv
tb/tb_dmi_jtag_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dmi_jtag_master
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
